// File: tests/qsound_cases.txt
// op addr data expected, all hex, one operation per line
// ff ends the list
01 1234 00 01234
01 8000 00 08000
02 d003 85 00
01 8123 00 1c123
01 bfff 00 1ffff
03 d007 00 f5
// mailbox: data hi, data lo, then address
02 d000 12 00
02 d001 34 00
02 d002 56 00
04 0000 01 0056
03 d007 00 75
05 0000 00 00
04 0000 00 1234
03 d007 00 f5
// sample-ROM address
06 0000 beef 00
07 8055 00 00
08 0000 00 55beef
// stereo pair, psel low gives left
09 0000 1111 00
09 0001 fedc 00
0a 0000 1111 fedc
09 0000 8001 00
09 0001 7ffe 00
0a 0000 8001 7ffe
// M68000 takeover
0b 0000 00 00
0c 00c010 a5 a5
0c 00f3ff 3c 3c
0d 012345 00 12345
0e 0000 00 00
// opcode-fetch wait state
0f 4000 00 01
0f 1000 00 00
0f 5000 00 01
// interrupt timer
10 0000 00 7d00
11 0000 00 00
ff 0000 00 00

// File: flist.f
design/qsnd_pkg.sv
design/z80_bus_decode.sv
design/z80_cpu_timing.sv
design/m68_bus_lock.sv
design/dsp_host_port.sv
design/dsp_sample_capture.sv
design/qsound_glue.sv
tests/tb_qsound_glue.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_qsound_glue
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_qsound_glue.sv
/*
 * Testbench for the QSound glue top level. Runs the operations listed in
 * the cases file against the DUT and stops at the first mismatch.
 */
`timescale 1ns/1ns

module tb_qsound_glue;

    localparam int MAX_CASES = 64;

    logic                 clk48;
    logic                 rst;
    logic                 cen8;
    qsnd_pkg::z80_bus_t   z80;
    logic                 busak_n;
    logic [7:0]           cpu_din;
    logic                 cpu_cen;
    logic                 int_n;
    logic                 busrq_n;
    qsnd_pkg::m68_addr_t  main_addr;
    logic [7:0]           main_dout;
    logic [7:0]           main_din;
    logic                 main_ldswn;
    logic                 main_buse_n;
    logic                 main_busakn;
    logic                 main_waitn;
    qsnd_pkg::rom_addr_t  rom_addr;
    logic                 rom_cs;
    logic [7:0]           rom_data;
    logic                 rom_ok;
    logic [12:0]          ram_addr;
    logic                 ram_we;
    logic [7:0]           ram_din;
    logic [7:0]           ram_dout;
    qsnd_pkg::dsp_pins_t  dsp;
    logic                 dsp_rst;
    logic                 dsp_irq;
    logic [15:0]          pbus_in;
    qsnd_pkg::qsnd_addr_t qsnd_addr;
    qsnd_pkg::sample_t    left;
    qsnd_pkg::sample_t    right;
    logic                 sample;

    logic [31:0] cases_mem [0:4*MAX_CASES-1];
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    logic [31:0] rnd;
    int          seed = 47713;
    int          ncases;
    int          n;
    int          cnt;
    int          cyc = 0;
    int          limit = 0;

    qsound_glue UUT (.*);

    initial begin
        clk48 = 1'b0;
        forever #50 clk48 = ~clk48;
    end

    // cycles since reset release, also the watchdog
    always @(posedge clk48) begin
        if (!rst)
            cyc <= cyc + 1;
        if (limit > 0 && cyc >= limit) begin
            $display("timeout: run still going after %0d cycles", cyc);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_rom_addr(input qsnd_pkg::rom_addr_t got,
                                  input qsnd_pkg::rom_addr_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_qaddr(input qsnd_pkg::qsnd_addr_t got,
                               input qsnd_pkg::qsnd_addr_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_sample(input qsnd_pkg::sample_t got,
                                input qsnd_pkg::sample_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %0d, expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic drive_z80(input logic [15:0] addr, input logic [7:0] data, input logic wr);
        z80.addr   = addr;
        z80.dout   = data;
        z80.mreq_n = 1'b0;
        z80.rd_n   = wr;
        z80.wr_n   = ~wr;
    endtask

    task automatic release_z80();
        z80 = '{addr: 16'h0, dout: 8'h0, default: 1'b1};   // bus idle
    endtask

    initial begin
        rst         = 1'b1;
        cen8        = 1'b1;
        busak_n     = 1'b1;
        main_addr   = '0;
        main_dout   = 8'h00;
        main_ldswn  = 1'b1;
        main_buse_n = 1'b1;
        rom_data    = 8'h00;
        rom_ok      = 1'b1;
        ram_dout    = 8'h00;
        dsp         = '{sadd: 1'b1, pods_n: 1'b1, pids_n: 1'b1, default: '0};
        release_z80();
        $readmemh("tests/qsound_cases.txt", cases_mem);
        ncases = 0;
        while (ncases < MAX_CASES && cases_mem[4*ncases] !== 32'hff)
            ncases++;
        if (ncases == 0 || ncases == MAX_CASES) begin
            $display("case file missing or without end marker");
            stop_run();
        end
        limit = qsnd_pkg::INT_PERIOD + 200 * ncases;
        repeat (3) @(posedge clk48);
        @(negedge clk48);
        check_byte({7'd0, dsp_rst}, 8'd1, "dsp_rst in reset");
        rst = 1'b0;
        for (int i = 0; i < ncases; i++) begin
            op = cases_mem[4*i][7:0];
            a  = cases_mem[4*i+1];
            d  = cases_mem[4*i+2];
            e  = cases_mem[4*i+3];
            case (op)
                8'h01: begin                // program ROM read
                    rnd = $random(seed);
                    rom_data = rnd[7:0];
                    drive_z80(a[15:0], 8'h00, 1'b0);
                    @(negedge clk48);
                    check_rom_addr(rom_addr, e[18:0], "z80 rom_addr");
                    check_byte({7'd0, rom_cs}, 8'd1, "rom_cs");
                    check_byte(cpu_din, rom_data, "z80 rom data");
                    release_z80();
                    @(negedge clk48);
                    check_byte(main_din, rom_data, "main_din");    // one cycle behind cpu_din
                end
                8'h02: begin
                    drive_z80(a[15:0], d[7:0], 1'b1);
                    repeat (2) @(negedge clk48);    // byte lands one cycle after select
                    release_z80();
                    z80.dout = d[7:0];              // data outlives the write strobe
                    repeat (2) @(negedge clk48);
                    if (a[15:12] == qsnd_pkg::IO_PAGE && a[2:0] == qsnd_pkg::BANK_REG_OFS)
                        check_byte({7'd0, dsp_rst}, {7'd0, ~d[7]}, "dsp_rst");
                end
                8'h03: begin
                    drive_z80(a[15:0], 8'h00, 1'b0);
                    @(negedge clk48);
                    check_byte(cpu_din, e[7:0], "z80 read data");
                    release_z80();
                    @(negedge clk48);
                end
                8'h04: begin
                    check_byte({7'd0, dsp_irq}, d[7:0], "dsp_irq");
                    check_word(pbus_in, e[15:0], "pbus_in");
                end
                8'h05: begin
                    dsp.pids_n = 1'b0;
                    @(negedge clk48);
                    dsp.pids_n = 1'b1;
                    repeat (2) @(negedge clk48);
                end
                8'h06: begin
                    dsp.pbus_out = d[15:0];
                    dsp.pods_n   = 1'b0;
                    @(negedge clk48);
                    dsp.pods_n = 1'b1;
                    repeat (2) @(negedge clk48);
                end
                8'h07: begin
                    dsp.ab      = a[15:0];
                    dsp.cen_cko = 1'b1;
                    @(negedge clk48);
                    dsp.cen_cko = 1'b0;
                    dsp.ab      = 16'h0;
                    @(negedge clk48);
                end
                8'h08: check_qaddr(qsnd_addr, e[22:0], "qsnd_addr");
                8'h09: begin
                    dsp.psel = a[0];
                    @(negedge clk48);
                    dsp.serout = d[15:0];
                    dsp.sadd   = 1'b0;
                    @(negedge clk48);
                    dsp.sadd = 1'b1;
                    @(negedge clk48);
                end
                8'h0a: begin
                    dsp.psel = 1'b0;
                    @(negedge clk48);
                    dsp.psel = 1'b1;
                    cnt = 0;
                    repeat (4) begin
                        @(negedge clk48);
                        if (sample)
                            cnt++;
                    end
                    check_sample(left, d[15:0], "left");
                    check_sample(right, e[15:0], "right");
                    check_byte(8'(cnt), 8'd1, "sample pulses");
                end
                8'h0b: begin                // Z80 modelled as granting at once
                    main_buse_n = 1'b0;
                    busak_n     = 1'b0;
                    n = 0;
                    while (main_busakn && n < 10) begin
                        @(negedge clk48);
                        n++;
                    end
                    if (main_busakn) begin
                        $display("main_busakn did not fall within 10 cycles");
                        stop_run();
                    end
                    check_byte({7'd0, busrq_n}, 8'd0, "busrq_n");
                end
                8'h0c: begin
                    main_addr  = a[22:0];
                    main_dout  = d[7:0];
                    main_ldswn = 1'b0;
                    @(negedge clk48);
                    check_byte({7'd0, ram_we}, 8'd1, "ram_we");
                    check_byte(ram_din, e[7:0], "ram_din");
                    check_word({3'd0, ram_addr}, {3'd0, a[12:0]}, "ram_addr");  // 8 KB fold
                    main_ldswn = 1'b1;
                    main_addr  = '0;
                    @(negedge clk48);
                end
                8'h0d: begin                // ROM not ready
                    main_addr = a[22:0];
                    rom_ok    = 1'b0;
                    @(negedge clk48);
                    check_byte({7'd0, main_waitn}, 8'd0, "main_waitn");
                    check_byte({7'd0, main_busakn}, 8'd1, "main_busakn held");
                    check_rom_addr(rom_addr, e[18:0], "main rom_addr");
                    rom_ok    = 1'b1;
                    main_addr = '0;
                    @(negedge clk48);
                end
                8'h0e: begin
                    main_buse_n = 1'b1;
                    busak_n     = 1'b1;
                    n = 0;
                    while (!main_busakn && n < 10) begin
                        @(negedge clk48);
                        n++;
                    end
                    if (!main_busakn) begin
                        $display("main_busakn did not return high after release");
                        stop_run();
                    end
                    check_byte({7'd0, busrq_n}, 8'd1, "busrq_n released");
                end
                8'h0f: begin                // opcode fetch, count missing enables
                    drive_z80(a[15:0], 8'h00, 1'b0);
                    z80.m1_n = 1'b0;
                    cnt = 0;
                    repeat (6) begin
                        @(negedge clk48);
                        if (!cpu_cen)
                            cnt++;
                    end
                    release_z80();
                    @(negedge clk48);
                    check_byte(8'(cnt), e[7:0], "dropped cpu_cen");
                end
                8'h10: begin
                    n = 0;
                    while (int_n && n < qsnd_pkg::INT_PERIOD + 100) begin
                        @(negedge clk48);
                        n++;
                    end
                    if (int_n) begin
                        $display("int_n never fell");
                        stop_run();
                    end
                    check_word(16'(cyc), e[15:0], "int_n fall cycle");
                end
                8'h11: begin                // interrupt acknowledge cycle
                    z80.m1_n   = 1'b0;
                    z80.iorq_n = 1'b0;
                    @(negedge clk48);
                    release_z80();
                    @(negedge clk48);
                    check_byte({7'd0, int_n}, 8'd1, "int_n after ack");
                end
                default: begin
                    $display("unknown operation %h in case %0d", op, i);
                    stop_run();
                end
            endcase
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: design/qsound_glue.sv
/*
 * QSound sound-board glue, top level. Connects the external Z80, M68000,
 * ROM, RAM and DSP16 pins to the decoder, timers, bus lock and DSP ports.
 */
`timescale 1ns/1ns

module qsound_glue (
    input  logic                  clk48,
    input  logic                  rst,
    input  logic                  cen8,
    // Z80
    input  qsnd_pkg::z80_bus_t    z80,
    input  logic                  busak_n,
    output logic [7:0]            cpu_din,
    output logic                  cpu_cen,
    output logic                  int_n,
    output logic                  busrq_n,
    // M68000
    input  qsnd_pkg::m68_addr_t   main_addr,
    input  logic [7:0]            main_dout,
    output logic [7:0]            main_din,
    input  logic                  main_ldswn,
    input  logic                  main_buse_n,
    output logic                  main_busakn,
    output logic                  main_waitn,
    // program ROM and work RAM
    output qsnd_pkg::rom_addr_t   rom_addr,
    output logic                  rom_cs,
    input  logic [7:0]            rom_data,
    input  logic                  rom_ok,
    output logic [12:0]           ram_addr,
    output logic                  ram_we,
    output logic [7:0]            ram_din,
    input  logic [7:0]            ram_dout,
    // DSP16
    input  qsnd_pkg::dsp_pins_t   dsp,
    output logic                  dsp_rst,
    output logic                  dsp_irq,
    output logic [15:0]           pbus_in,
    output qsnd_pkg::qsnd_addr_t  qsnd_addr,
    // audio
    output qsnd_pkg::sample_t     left,
    output qsnd_pkg::sample_t     right,
    output logic                  sample
);

    logic                main_busn;     // low while the M68000 owns the bus
    qsnd_pkg::chip_sel_t sel;

    m68_bus_lock u_bus_lock (
        .clk48     (clk48),
        .rst       (rst),
        .cen8      (cen8),
        .buse_n    (main_buse_n),
        .busak_n   (busak_n),
        .busrq_n   (busrq_n),
        .main_busn (main_busn)
    );

    z80_bus_decode u_decode (
        .clk48       (clk48),
        .rst         (rst),
        .z80         (z80),
        .main_busn   (main_busn),
        .main_addr   (main_addr),
        .main_dout   (main_dout),
        .main_ldswn  (main_ldswn),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .ram_dout    (ram_dout),
        .dsp_irq     (dsp_irq),
        .dsp_iack    (dsp.iack),
        .sel         (sel),
        .bus_din     (ram_din),         // also the mailbox write byte
        .rom_addr    (rom_addr),
        .rom_cs      (rom_cs),
        .ram_addr    (ram_addr),
        .ram_we      (ram_we),
        .cpu_din     (cpu_din),
        .main_din    (main_din),
        .main_busakn (main_busakn),
        .main_waitn  (main_waitn),
        .dsp_rst     (dsp_rst)
    );

    z80_cpu_timing u_timing (
        .clk48   (clk48),
        .rst     (rst),
        .cen8    (cen8),
        .z80     (z80),
        .int_n   (int_n),
        .cpu_cen (cpu_cen)
    );

    dsp_host_port u_host_port (
        .clk48     (clk48),
        .rst       (rst),
        .sel       (sel),
        .bus_din   (ram_din),
        .dsp       (dsp),
        .dsp_irq   (dsp_irq),
        .pbus_in   (pbus_in),
        .qsnd_addr (qsnd_addr)
    );

    dsp_sample_capture u_capture (
        .clk48  (clk48),
        .rst    (rst),
        .dsp    (dsp),
        .left   (left),
        .right  (right),
        .sample (sample)
    );

endmodule

// File: design/dsp_sample_capture.sv
/*
 * Stereo sample capture from the DSP16 serial side. Words are taken in
 * parallel on sadd falls and released as a pair on a psel rise.
 */
`timescale 1ns/1ns

module dsp_sample_capture (
    input  logic                 clk48,
    input  logic                 rst,
    input  qsnd_pkg::dsp_pins_t  dsp,
    output qsnd_pkg::sample_t    left,
    output qsnd_pkg::sample_t    right,
    output logic                 sample
);

    qsnd_pkg::sample_t pend_l;
    qsnd_pkg::sample_t pend_r;
    logic              last_sadd;
    logic              last_psel;

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            last_sadd <= 1'b0;
            last_psel <= 1'b1;              // no false rise out of reset
            sample    <= 1'b0;
        end else begin
            last_sadd <= dsp.sadd;
            last_psel <= dsp.psel;
            sample    <= dsp.psel && !last_psel;
        end
    end

    always_ff @(posedge clk48) begin
        if (!dsp.sadd && last_sadd) begin
            if (!dsp.psel)
                pend_l <= dsp.serout;
            else
                pend_r <= dsp.serout;
        end
        if (dsp.psel && !last_psel) begin
            left  <= pend_l;                // both channels change together
            right <= pend_r;
        end
    end

endmodule

// File: design/dsp_host_port.sv
/*
 * CPU to DSP16 mailbox and sample-ROM address latch. The Z80 fills the
 * mailbox bytes, the DSP reads them back over its parallel input port.
 */
`timescale 1ns/1ns

module dsp_host_port (
    input  logic                  clk48,
    input  logic                  rst,
    input  qsnd_pkg::chip_sel_t   sel,
    input  logic [7:0]            bus_din,
    input  qsnd_pkg::dsp_pins_t   dsp,
    output logic                  dsp_irq,
    output logic [15:0]           pbus_in,
    output qsnd_pkg::qsnd_addr_t  qsnd_addr
);

    qsnd_pkg::mbox_word_u mbox;
    logic [1:0]           datasel;
    logic                 last_pids_n;
    logic                 last_pods_n;
    logic                 pids_rise;
    logic                 pods_rise;
    logic                 addr_wr;

    assign pids_rise = dsp.pids_n && !last_pids_n;
    assign pods_rise = dsp.pods_n && !last_pods_n;
    assign addr_wr   = sel.mbox_wr && sel.ofs == qsnd_pkg::MBOX_ADDR;

    // mailbox bytes, one per offset
    always_ff @(posedge clk48) begin
        if (sel.mbox_wr)
            mbox.bytes[sel.ofs[1:0]] <= bus_din;
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            last_pids_n <= 1'b1;
            last_pods_n <= 1'b1;
        end else begin
            last_pids_n <= dsp.pids_n;
            last_pods_n <= dsp.pods_n;
        end
    end

    // address byte first, then the data word
    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            dsp_irq <= 1'b0;
            datasel <= 2'b00;
        end else begin
            if (addr_wr) begin
                dsp_irq <= 1'b1;
                datasel <= 2'b11;
            end else if (pids_rise) begin
                dsp_irq <= 1'b0;            // DSP took the address
                datasel <= datasel >> 1;
            end
        end
    end

    assign pbus_in = datasel[1] ? {8'd0, mbox.dsp.addr} : mbox.dsp.data;

    // sample-ROM address, low half from the parallel port
    always_ff @(posedge clk48) begin
        if (pods_rise)
            qsnd_addr[15:0] <= dsp.pbus_out;
        if (dsp.ab[15] && dsp.cen_cko)
            qsnd_addr[22:16] <= dsp.ab[6:0];    // upper bits ride on the address bus
    end

endmodule

// File: design/m68_bus_lock.sv
/*
 * Hands the Z80 bus to the M68000. The request goes straight to the Z80,
 * the grant follows its bus acknowledge after two cen8 ticks.
 */
`timescale 1ns/1ns

module m68_bus_lock (
    input  logic clk48,
    input  logic rst,
    input  logic cen8,
    input  logic buse_n,
    input  logic busak_n,
    output logic busrq_n,
    output logic main_busn
);

    logic [1:0] latch;

    assign busrq_n = buse_n;

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            latch <= 2'b11;
        end else begin
            if (buse_n)
                latch <= 2'b11;
            else if (cen8)
                latch <= {latch[0], busak_n};
        end
    end

    // request released, grant goes at once
    assign main_busn = latch[1] | busrq_n;

endmodule

// File: design/z80_cpu_timing.sv
/*
 * Z80 interrupt timer and opcode-fetch wait state. Drives int_n and the
 * gated clock enable of the external Z80.
 */
`timescale 1ns/1ns

module z80_cpu_timing (
    input  logic               clk48,
    input  logic               rst,
    input  logic               cen8,
    input  qsnd_pkg::z80_bus_t z80,
    output logic               int_n,
    output logic               cpu_cen
);

    logic [14:0] cnt;
    logic        cnt_over;
    logic        fetch_hi;
    logic        skip;      // swallow the next cen8
    logic        done;      // this fetch already got its wait

    assign cnt_over = cnt == 15'(qsnd_pkg::INT_PERIOD - 1);

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            cnt   <= 15'd0;
            int_n <= 1'b1;
        end else begin
            if (cen8)
                cnt <= cnt_over ? 15'd0 : cnt + 15'd1;
            if (!z80.m1_n && !z80.iorq_n)
                int_n <= 1'b1;              // interrupt acknowledge cycle
            else if (cen8 && cnt_over)
                int_n <= 1'b0;
        end
    end

    assign fetch_hi = !z80.m1_n && !z80.mreq_n && z80.addr[15:12] >= qsnd_pkg::WAIT_PAGE_MIN;

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            skip <= 1'b0;
            done <= 1'b0;
        end else begin
            if (z80.m1_n)
                done <= 1'b0;               // re-arm for the next fetch
            if (cen8) begin
                if (skip) begin
                    skip <= 1'b0;
                end else if (fetch_hi && !done) begin
                    skip <= 1'b1;
                    done <= 1'b1;
                end
            end
        end
    end

    assign cpu_cen = cen8 & ~skip;

endmodule

// File: design/z80_bus_decode.sv
/*
 * Sound bus decoder. Muxes the Z80 or the M68000 onto the bus, registers
 * the chip selects and ROM address, keeps the bank register and builds read data.
 */
`timescale 1ns/1ns

module z80_bus_decode (
    input  logic                  clk48,
    input  logic                  rst,
    input  qsnd_pkg::z80_bus_t    z80,
    input  logic                  main_busn,
    input  qsnd_pkg::m68_addr_t   main_addr,
    input  logic [7:0]            main_dout,
    input  logic                  main_ldswn,
    input  logic [7:0]            rom_data,
    input  logic                  rom_ok,
    input  logic [7:0]            ram_dout,
    input  logic                  dsp_irq,
    input  logic                  dsp_iack,
    output qsnd_pkg::chip_sel_t   sel,
    output logic [7:0]            bus_din,
    output qsnd_pkg::rom_addr_t   rom_addr,
    output logic                  rom_cs,
    output logic [12:0]           ram_addr,
    output logic                  ram_we,
    output logic [7:0]            cpu_din,
    output logic [7:0]            main_din,
    output logic                  main_busakn,
    output logic                  main_waitn,
    output logic                  dsp_rst
);

    logic [15:0]         bus_a;
    logic                bus_wrn;
    logic                bus_rdn;
    logic                bus_mreqn;
    logic [3:0]          page;
    logic [2:0]          ofs;
    logic                io_acc;
    logic [3:0]          bank;
    logic                dsp_rdy_n;
    logic                main_busn_dly;
    qsnd_pkg::rom_addr_t z80_rom_addr;

    // M68000 side takes over while main_busn is low
    assign bus_a     = main_busn ? z80.addr : main_addr[16:1];
    assign bus_wrn   = main_busn ? z80.wr_n : main_ldswn;
    assign bus_rdn   = main_busn ? z80.rd_n : ~main_ldswn;
    assign bus_din   = main_busn ? z80.dout : main_dout;
    assign bus_mreqn = main_busn & z80.mreq_n;

    assign page   = bus_a[15:12];
    assign ofs    = bus_a[2:0];
    assign io_acc = !bus_mreqn && page == qsnd_pkg::IO_PAGE;

    // 0x8000-0xBFFF is a 16 KB window into ROM above BANK_ROM_BASE
    assign z80_rom_addr = bus_a[15] ? ({1'b0, bank, bus_a[13:0]} + qsnd_pkg::BANK_ROM_BASE)
                                    : {4'd0, bus_a[14:0]};

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            sel      <= '0;
            rom_addr <= '0;
        end else begin
            sel.rom     <= !bus_mreqn && (!bus_a[15] || bus_a[15:14] == 2'b10);
            sel.ram     <= !bus_mreqn && (page == qsnd_pkg::RAM_PAGE_LO ||
                                          page == qsnd_pkg::RAM_PAGE_HI);
            sel.mbox_wr <= io_acc && !bus_wrn && (ofs == qsnd_pkg::MBOX_DATA_HI ||
                                                  ofs == qsnd_pkg::MBOX_DATA_LO ||
                                                  ofs == qsnd_pkg::MBOX_ADDR);
            sel.bank_wr   <= io_acc && !bus_wrn && ofs == qsnd_pkg::BANK_REG_OFS;
            sel.status_rd <= io_acc && !bus_rdn && ofs == qsnd_pkg::STATUS_OFS;
            sel.ofs       <= ofs;
            if (!bus_mreqn) begin
                rom_addr <= main_busn ? z80_rom_addr : main_addr[19:1];
            end
        end
    end

    // bank number and DSP reset share one register
    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            bank          <= 4'd0;
            dsp_rst       <= 1'b1;
            main_busn_dly <= 1'b1;
        end else begin
            main_busn_dly <= main_busn;
            if (sel.bank_wr) begin
                bank    <= bus_din[3:0];
                dsp_rst <= ~bus_din[7];     // bit 7 set lets the DSP run
            end
        end
    end

    always_ff @(posedge clk48) begin
        main_din <= cpu_din;
    end

    assign rom_cs   = sel.rom;
    assign ram_addr = bus_a[12:0];          // C and F pages fold onto 8 KB
    assign ram_we   = sel.ram && !bus_wrn;

    // DSP still busy while the irq is pending or being acknowledged
    assign dsp_rdy_n = ~(dsp_irq | dsp_iack);

    always_comb begin
        if (sel.rom)
            cpu_din = rom_data;
        else if (sel.ram)
            cpu_din = ram_dout;
        else if (sel.status_rd)
            cpu_din = {dsp_rdy_n, 3'b111, bank};
        else
            cpu_din = 8'hff;                // open bus
    end

    // M68000 is held off until the ROM data is there
    assign main_busakn = main_busn_dly | (sel.rom & ~rom_ok);
    assign main_waitn  = main_busn | ~sel.rom | rom_ok;

endmodule

// File: design/qsnd_pkg.sv
/*
 * Shared constants and bus types for the QSound sound-board glue.
 * Every design file refers to these by scoped name.
 */
package qsnd_pkg;

    // Z80 timing
    localparam int INT_PERIOD = 32000;              // cen8 ticks between interrupts
    localparam logic [3:0] WAIT_PAGE_MIN = 4'h4;    // opcode fetch from 0x4000 up waits

    // Z80 memory map, 4 KB pages
    localparam logic [18:0] BANK_ROM_BASE = 19'h08000;
    localparam logic [3:0] RAM_PAGE_LO = 4'hC;
    localparam logic [3:0] RAM_PAGE_HI = 4'hF;
    localparam logic [3:0] IO_PAGE = 4'hD;

    // register offsets inside IO_PAGE
    localparam logic [2:0] MBOX_DATA_HI = 3'd0;
    localparam logic [2:0] MBOX_DATA_LO = 3'd1;
    localparam logic [2:0] MBOX_ADDR = 3'd2;     // writing this one interrupts the DSP
    localparam logic [2:0] BANK_REG_OFS = 3'd3;
    localparam logic [2:0] STATUS_OFS = 3'd7;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;
        logic        mreq_n;
        logic        rd_n;
        logic        wr_n;
        logic        m1_n;
        logic        iorq_n;
    } z80_bus_t;

    typedef logic [23:1] m68_addr_t;          // word address
    typedef logic [18:0] rom_addr_t;          // 512 KB program ROM
    typedef logic [22:0] qsnd_addr_t;         // up to 8 MB of samples
    typedef logic signed [15:0] sample_t;

    typedef struct packed {
        logic       rom;
        logic       ram;
        logic       mbox_wr;
        logic       bank_wr;
        logic       status_rd;
        logic [2:0] ofs;
    } chip_sel_t;

    // data word in the upper bytes so the byte view follows the mailbox offsets
    typedef union packed {
        struct packed {
            logic [15:0] data;
            logic [7:0]  addr;
        } dsp;
        logic [0:2][7:0] bytes;               // bytes[n] is mailbox offset n
    } mbox_word_u;

    typedef struct packed {
        logic [15:0] ab;
        logic [15:0] pbus_out;
        logic        pods_n;
        logic        pids_n;
        logic        sadd;
        logic        psel;
        logic [15:0] serout;
        logic        cen_cko;
        logic        iack;
    } dsp_pins_t;

endpackage
